//--- fifoctl_cfg_pkg.sv
package fifoctl_cfg_pkg;

	// ------------------------------
	// FIFO geometry
	// ------------------------------

	// Number of RAM words, power of 2 only
	localparam int DEF_DEPTH = 16;

	// ------------------------------
	// Flag thresholds
	// ------------------------------

	// Push side
	localparam int DEF_PUSH_AE_LVL = 2;
	localparam int DEF_PUSH_AF_LVL = 3;

	// Pop side
	localparam int DEF_POP_AE_LVL = 3;
	localparam int DEF_POP_AF_LVL = 3;

	// Synchronizer depth, 2 or 3 flops
	localparam int DEF_SYNC_STAGES = 2;

endpackage

//--- fifoctl_ptr_pkg.sv
package fifoctl_ptr_pkg;

	// Widest pointer the helpers handle
	localparam int MAX_PTR_W = 32;

	typedef logic [MAX_PTR_W-1:0] ptr_word_t;

	// Ones in the low ptr_w bits
	function automatic ptr_word_t width_mask(input int ptr_w);
		return (ptr_word_t'(1) << ptr_w) - ptr_word_t'(1);
	endfunction

	function automatic ptr_word_t bin_to_gray(input ptr_word_t bin, input int ptr_w);
		return (bin ^ (bin >> 1)) & width_mask(ptr_w);
	endfunction

	// Each binary bit is the XOR of all Gray bits at and above it
	function automatic ptr_word_t gray_to_bin(input ptr_word_t gray, input int ptr_w);
		ptr_word_t bin;
		bin = gray;
		for (int i = 1; i < ptr_w; i++)
		begin
			bin = bin ^ (gray >> i);
		end
		return bin & width_mask(ptr_w);
	endfunction

	// Words held, wr minus rd modulo 2*depth, so 0 to depth
	function automatic ptr_word_t fill_count(input ptr_word_t wr_ptr, input ptr_word_t rd_ptr,
		input int ptr_w);
		return (wr_ptr - rd_ptr) & width_mask(ptr_w);
	endfunction

endpackage

//--- ptr_sync.sv
`timescale 1ns/10ps

module ptr_sync
	import fifoctl_ptr_pkg::*;
#(
	parameter int depth = 8,
	parameter int sync_stages = 2,
	localparam int addr_w = $clog2(depth),
	localparam int ptr_w = addr_w + 1
)
(
	input  logic             clk_src,
	input  logic             clk_dst,
	input  logic             rst_n,
	input  logic [ptr_w-1:0] ptr_in,
	output logic [ptr_w-1:0] ptr_out
);

	ptr_word_t                          gray_wide;
	ptr_word_t                          bin_wide;
	logic [ptr_w-1:0]                   gray_src;
	logic [sync_stages-1:0][ptr_w-1:0]  sync_q;

	// ------------------------------
	// Source clock domain
	// ------------------------------

	assign gray_wide = bin_to_gray(ptr_word_t'(ptr_in), ptr_w);

	// Registered Gray code, so only one bit moves per pointer step
	always_ff @(posedge clk_src or negedge rst_n)
	begin
		if (!rst_n)
		begin
			gray_src <= '0;
		end
		else
		begin
			gray_src <= gray_wide[ptr_w-1:0];
		end
	end

	// ------------------------------
	// Destination clock domain
	// ------------------------------

	// Stage 0 is the metastable capture flop
	always_ff @(posedge clk_dst or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync_q <= '0;
		end
		else
		begin
			sync_q <= {sync_q[sync_stages-2:0], gray_src};
		end
	end

	// Back to binary for the count arithmetic
	assign bin_wide = gray_to_bin(ptr_word_t'(sync_q[sync_stages-1]), ptr_w);
	assign ptr_out = bin_wide[ptr_w-1:0];

endmodule

//--- status_flags.sv
`timescale 1ns/10ps

module status_flags
	import fifoctl_ptr_pkg::*;
#(
	parameter int depth = 8,
	parameter int ae_lvl = 1,
	parameter int af_lvl = 1,
	localparam int addr_w = $clog2(depth),
	localparam int ptr_w = addr_w + 1
)
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic [ptr_w-1:0] wr_ptr_nxt,
	input  logic [ptr_w-1:0] rd_ptr_nxt,
	output logic             empty,
	output logic             ae,
	output logic             hf,
	output logic             af,
	output logic             full
);

	// Thresholds at count width
	localparam logic [ptr_w-1:0] ae_thr = ptr_w'(ae_lvl);
	localparam logic [ptr_w-1:0] hf_thr = ptr_w'(depth / 2);
	localparam logic [ptr_w-1:0] af_thr = ptr_w'(depth - af_lvl);
	localparam logic [ptr_w-1:0] full_cnt = ptr_w'(depth);

	ptr_word_t        count_wide;
	logic [ptr_w-1:0] count;

	// Count from next pointers, so a transfer on this edge is included
	assign count_wide = fill_count(ptr_word_t'(wr_ptr_nxt), ptr_word_t'(rd_ptr_nxt), ptr_w);
	assign count = count_wide[ptr_w-1:0];

	// ------------------------------
	// Registered flags
	// ------------------------------

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			empty <= 1'b1;
			ae    <= 1'b1;
			hf    <= 1'b0;
			af    <= 1'b0;
			full  <= 1'b0;
		end
		else
		begin
			empty <= (count == '0);
			ae    <= (count <= ae_thr);
			// Qualified by the previous ae, one cycle behind
			hf    <= (count >= hf_thr) && !ae;
			af    <= (count >= af_thr);
			full  <= (count == full_cnt);
		end
	end

endmodule

//--- push_ctl.sv
`timescale 1ns/10ps

module push_ctl
#(
	parameter int depth = 8,
	parameter int ae_lvl = 1,
	parameter int af_lvl = 1,
	localparam int addr_w = $clog2(depth),
	localparam int ptr_w = addr_w + 1
)
(
	input  logic              clk_push,
	input  logic              rst_n,
	input  logic              write_allow,
	input  logic              push_req_n,
	input  logic [ptr_w-1:0]  rd_ptr_sync,
	output logic [ptr_w-1:0]  wr_ptr,
	output logic [addr_w-1:0] wr_addr,
	output logic              we_n,
	output logic              push_empty,
	output logic              push_ae,
	output logic              push_hf,
	output logic              push_af,
	output logic              push_full,
	output logic              push_error
);

	logic [ptr_w-1:0] wr_ptr_nxt;

	// RAM write strobe follows the allow level directly
	assign we_n = ~write_allow;

	// ------------------------------
	// Write pointer
	// ------------------------------

	// Wrap bit rolls over naturally at 2*depth
	assign wr_ptr_nxt = write_allow ? wr_ptr + ptr_w'(1) : wr_ptr;

	always_ff @(posedge clk_push or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
		end
		else
		begin
			wr_ptr <= wr_ptr_nxt;
		end
	end

	// Address drops the wrap bit
	assign wr_addr = wr_ptr[addr_w-1:0];

	// Request while full, reported on the next edge
	always_ff @(posedge clk_push or negedge rst_n)
	begin
		if (!rst_n)
		begin
			push_error <= 1'b0;
		end
		else
		begin
			push_error <= ~push_req_n & push_full;
		end
	end

	status_flags #(
		.depth  (depth),
		.ae_lvl (ae_lvl),
		.af_lvl (af_lvl)
	) u_flags (
		.clk        (clk_push),
		.rst_n      (rst_n),
		.wr_ptr_nxt (wr_ptr_nxt),
		.rd_ptr_nxt (rd_ptr_sync),
		.empty      (push_empty),
		.ae         (push_ae),
		.hf         (push_hf),
		.af         (push_af),
		.full       (push_full)
	);

endmodule

//--- pop_ctl.sv
`timescale 1ns/10ps

module pop_ctl
#(
	parameter int depth = 8,
	parameter int ae_lvl = 1,
	parameter int af_lvl = 1,
	localparam int addr_w = $clog2(depth),
	localparam int ptr_w = addr_w + 1
)
(
	input  logic              clk_pop,
	input  logic              rst_n,
	input  logic              ren,
	input  logic              pop_req_n,
	input  logic [ptr_w-1:0]  wr_ptr_sync,
	output logic [ptr_w-1:0]  rd_ptr,
	output logic [addr_w-1:0] rd_addr,
	output logic              pop_empty,
	output logic              pop_ae,
	output logic              pop_hf,
	output logic              pop_af,
	output logic              pop_full,
	output logic              pop_error
);

	logic [ptr_w-1:0] rd_ptr_nxt;

	// ------------------------------
	// Read pointer
	// ------------------------------

	assign rd_ptr_nxt = ren ? rd_ptr + ptr_w'(1) : rd_ptr;

	always_ff @(posedge clk_pop or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_ptr <= '0;
		end
		else
		begin
			rd_ptr <= rd_ptr_nxt;
		end
	end

	// Asynchronous RAM read port sees this directly
	assign rd_addr = rd_ptr[addr_w-1:0];

	// Request while empty
	always_ff @(posedge clk_pop or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pop_error <= 1'b0;
		end
		else
		begin
			pop_error <= ~pop_req_n & pop_empty;
		end
	end

	// Remote write pointer against local next read pointer
	status_flags #(
		.depth  (depth),
		.ae_lvl (ae_lvl),
		.af_lvl (af_lvl)
	) u_flags (
		.clk        (clk_pop),
		.rst_n      (rst_n),
		.wr_ptr_nxt (wr_ptr_sync),
		.rd_ptr_nxt (rd_ptr_nxt),
		.empty      (pop_empty),
		.ae         (pop_ae),
		.hf         (pop_hf),
		.af         (pop_af),
		.full       (pop_full)
	);

endmodule

//--- fifoctl_top.sv
`timescale 1ns/10ps

module fifoctl_top
	import fifoctl_cfg_pkg::*;
#(
	parameter int depth = DEF_DEPTH,
	parameter int push_ae_lvl = DEF_PUSH_AE_LVL,
	parameter int push_af_lvl = DEF_PUSH_AF_LVL,
	parameter int pop_ae_lvl = DEF_POP_AE_LVL,
	parameter int pop_af_lvl = DEF_POP_AF_LVL,
	parameter int sync_stages = DEF_SYNC_STAGES,
	localparam int addr_w = $clog2(depth),
	localparam int ptr_w = addr_w + 1
)
(
	input  logic              clk_push,
	input  logic              clk_pop,
	input  logic              rst_n,
	input  logic              write_allow,
	input  logic              push_req_n,
	input  logic              ren,
	input  logic              pop_req_n,
	output logic              we_n,
	output logic [addr_w-1:0] wr_addr,
	output logic              push_empty,
	output logic              push_ae,
	output logic              push_hf,
	output logic              push_af,
	output logic              push_full,
	output logic              push_error,
	output logic [addr_w-1:0] rd_addr,
	output logic              pop_empty,
	output logic              pop_ae,
	output logic              pop_hf,
	output logic              pop_af,
	output logic              pop_full,
	output logic              pop_error
);

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] wr_ptr_sync;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] rd_ptr_sync;

	// ------------------------------
	// Push clock domain
	// ------------------------------

	push_ctl #(
		.depth  (depth),
		.ae_lvl (push_ae_lvl),
		.af_lvl (push_af_lvl)
	) u_push (
		.clk_push    (clk_push),
		.rst_n       (rst_n),
		.write_allow (write_allow),
		.push_req_n  (push_req_n),
		.rd_ptr_sync (rd_ptr_sync),
		.wr_ptr      (wr_ptr),
		.wr_addr     (wr_addr),
		.we_n        (we_n),
		.push_empty  (push_empty),
		.push_ae     (push_ae),
		.push_hf     (push_hf),
		.push_af     (push_af),
		.push_full   (push_full),
		.push_error  (push_error)
	);

	// Write pointer into pop domain
	ptr_sync #(
		.depth       (depth),
		.sync_stages (sync_stages)
	) u_wr_sync (
		.clk_src (clk_push),
		.clk_dst (clk_pop),
		.rst_n   (rst_n),
		.ptr_in  (wr_ptr),
		.ptr_out (wr_ptr_sync)
	);

	// ------------------------------
	// Pop clock domain
	// ------------------------------

	pop_ctl #(
		.depth  (depth),
		.ae_lvl (pop_ae_lvl),
		.af_lvl (pop_af_lvl)
	) u_pop (
		.clk_pop     (clk_pop),
		.rst_n       (rst_n),
		.ren         (ren),
		.pop_req_n   (pop_req_n),
		.wr_ptr_sync (wr_ptr_sync),
		.rd_ptr      (rd_ptr),
		.rd_addr     (rd_addr),
		.pop_empty   (pop_empty),
		.pop_ae      (pop_ae),
		.pop_hf      (pop_hf),
		.pop_af      (pop_af),
		.pop_full    (pop_full),
		.pop_error   (pop_error)
	);

	// Read pointer back into push domain
	ptr_sync #(
		.depth       (depth),
		.sync_stages (sync_stages)
	) u_rd_sync (
		.clk_src (clk_pop),
		.clk_dst (clk_push),
		.rst_n   (rst_n),
		.ptr_in  (rd_ptr),
		.ptr_out (rd_ptr_sync)
	);

endmodule

//--- tb_fifoctl.sv
`timescale 1ns/10ps

module tb_fifoctl
	import fifoctl_cfg_pkg::*;
	import fifoctl_ptr_pkg::*;
();

	localparam int depth = DEF_DEPTH;
	localparam int addr_w = $clog2(depth);
	localparam int ptr_w = addr_w + 1;
	localparam int settle_cycles = 10;
	localparam int timeout_cycles = 2000;

	logic              clk_push;
	logic              clk_pop;
	logic              rst_n;
	logic              write_allow;
	logic              push_req_n;
	logic              ren;
	logic              pop_req_n;
	logic              we_n;
	logic [addr_w-1:0] wr_addr;
	logic [addr_w-1:0] rd_addr;
	logic              push_empty;
	logic              push_ae;
	logic              push_hf;
	logic              push_af;
	logic              push_full;
	logic              push_error;
	logic              pop_empty;
	logic              pop_ae;
	logic              pop_hf;
	logic              pop_af;
	logic              pop_full;
	logic              pop_error;
	logic [4:0]        push_flags;
	logic [4:0]        pop_flags;

	// Model pointers that step once per accepted transfer
	ptr_word_t wr_m;
	ptr_word_t rd_m;
	int        err_count;
	int        test_err_start;
	int        tests_passed;
	int        tests_failed;
	int        cycles;
	string     cur_test;

	assign push_flags = {push_empty, push_ae, push_hf, push_af, push_full};
	assign pop_flags = {pop_empty, pop_ae, pop_hf, pop_af, pop_full};

	fifoctl_top #(
		.depth       (DEF_DEPTH),
		.push_ae_lvl (DEF_PUSH_AE_LVL),
		.push_af_lvl (DEF_PUSH_AF_LVL),
		.pop_ae_lvl  (DEF_POP_AE_LVL),
		.pop_af_lvl  (DEF_POP_AF_LVL),
		.sync_stages (DEF_SYNC_STAGES)
	) u_dut (
		.clk_push    (clk_push),
		.clk_pop     (clk_pop),
		.rst_n       (rst_n),
		.write_allow (write_allow),
		.push_req_n  (push_req_n),
		.ren         (ren),
		.pop_req_n   (pop_req_n),
		.we_n        (we_n),
		.wr_addr     (wr_addr),
		.push_empty  (push_empty),
		.push_ae     (push_ae),
		.push_hf     (push_hf),
		.push_af     (push_af),
		.push_full   (push_full),
		.push_error  (push_error),
		.rd_addr     (rd_addr),
		.pop_empty   (pop_empty),
		.pop_ae      (pop_ae),
		.pop_hf      (pop_hf),
		.pop_af      (pop_af),
		.pop_full    (pop_full),
		.pop_error   (pop_error)
	);

	// ------------------------------
	// Clocks and timeout
	// ------------------------------

	initial
	begin
		clk_push = 1'b0;
		forever #2 clk_push = ~clk_push;
	end

	initial
	begin
		clk_pop = 1'b0;
		forever #3 clk_pop = ~clk_pop;
	end

	initial
	begin
		cycles = 0;
		while (cycles < timeout_cycles)
		begin
			@(posedge clk_push);
			cycles++;
		end
		$display("Timeout: run went past %0d clk_push cycles", timeout_cycles);
		$display("Test failed");
		$finish;
	end

	// ------------------------------
	// Model and helpers
	// ------------------------------

	function automatic int model_count();
		return int'(fill_count(wr_m, rd_m, ptr_w));
	endfunction

	// Expected flag vector {empty, ae, hf, af, full}
	// The hf term takes ae from the previous edge
	function automatic logic [4:0] exp_flags(input int count, input int ae_lvl,
		input int af_lvl, input logic prev_ae);
		logic [4:0] f;
		f[4] = (count == 0);
		f[3] = (count <= ae_lvl);
		f[2] = (count >= depth / 2) && !prev_ae;
		f[1] = (count >= depth - af_lvl);
		f[0] = (count == depth);
		return f;
	endfunction

	task automatic check_val(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			err_count++;
			$display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
		end
	endtask

	task automatic push_edge();
		@(posedge clk_push);
		#1;
	endtask

	task automatic pop_edge();
		@(posedge clk_pop);
		#1;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err_start = err_count;
	endtask

	task automatic end_test();
		if (err_count == test_err_start)
		begin
			tests_passed++;
			$display("[PASS] %s", cur_test);
		end
		else
		begin
			tests_failed++;
			$display("[FAIL] %s with %0d errors", cur_test, err_count - test_err_start);
		end
	endtask

	// Flags once the remote pointer has settled and ae is steady
	task automatic check_push_steady();
		int cnt;
		cnt = model_count();
		check_val("push flags", 32'(exp_flags(cnt, DEF_PUSH_AE_LVL, DEF_PUSH_AF_LVL,
			cnt <= DEF_PUSH_AE_LVL)), 32'(push_flags));
	endtask

	task automatic check_pop_steady();
		int cnt;
		cnt = model_count();
		check_val("pop flags", 32'(exp_flags(cnt, DEF_POP_AE_LVL, DEF_POP_AF_LVL,
			cnt <= DEF_POP_AE_LVL)), 32'(pop_flags));
	endtask

	task automatic write_burst(input int n);
		logic       prev_ae;
		logic [4:0] exp;
		push_edge();
		prev_ae = (model_count() <= DEF_PUSH_AE_LVL);
		for (int i = 0; i < n; i++)
		begin
			write_allow = 1'b1;
			#0.1;
			check_val("we_n low", 32'(1'b0), 32'(we_n));
			push_edge();
			wr_m = wr_m + 1;
			exp = exp_flags(model_count(), DEF_PUSH_AE_LVL, DEF_PUSH_AF_LVL, prev_ae);
			prev_ae = exp[3];
			check_val("wr_addr", wr_m % depth, 32'(wr_addr));
			check_val("push flags", 32'(exp), 32'(push_flags));
		end
		write_allow = 1'b0;
		#0.1;
		check_val("we_n high", 32'(1'b1), 32'(we_n));
	endtask

	task automatic read_burst(input int n);
		logic       prev_ae;
		logic [4:0] exp;
		pop_edge();
		prev_ae = (model_count() <= DEF_POP_AE_LVL);
		for (int i = 0; i < n; i++)
		begin
			ren = 1'b1;
			pop_edge();
			rd_m = rd_m + 1;
			exp = exp_flags(model_count(), DEF_POP_AE_LVL, DEF_POP_AF_LVL, prev_ae);
			prev_ae = exp[3];
			check_val("rd_addr", rd_m % depth, 32'(rd_addr));
			check_val("pop flags", 32'(exp), 32'(pop_flags));
		end
		ren = 1'b0;
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------

	task automatic test_reset_values();
		start_test("reset_values");
		check_val("wr_addr", 0, 32'(wr_addr));
		check_val("rd_addr", 0, 32'(rd_addr));
		check_val("we_n", 32'(1'b1), 32'(we_n));
		check_val("push flags", 32'(5'b11000), 32'(push_flags));
		check_val("pop flags", 32'(5'b11000), 32'(pop_flags));
		check_val("push_error", 0, 32'(push_error));
		check_val("pop_error", 0, 32'(pop_error));
		end_test();
	endtask

	task automatic test_write_burst();
		int n;
		start_test("write_burst");
		n = 1 + int'($urandom % (depth - 1));
		write_burst(n);
		end_test();
	endtask

	task automatic test_cross_to_pop();
		start_test("cross_to_pop");
		repeat (settle_cycles) pop_edge();
		check_pop_steady();
		end_test();
	endtask

	task automatic test_fill_push_error();
		start_test("fill_push_error");
		// A request while not full raises no error
		push_edge();
		push_req_n = 1'b0;
		push_edge();
		check_val("push_error not full", 0, 32'(push_error));
		push_req_n = 1'b1;
		write_burst(depth - model_count());
		check_val("push_full", 32'(1'b1), 32'(push_full));
		repeat (settle_cycles) pop_edge();
		check_val("pop_full", 32'(1'b1), 32'(pop_full));
		check_pop_steady();
		// One request cycle while full
		push_edge();
		push_req_n = 1'b0;
		push_edge();
		check_val("push_error set", 32'(1'b1), 32'(push_error));
		push_req_n = 1'b1;
		push_edge();
		check_val("push_error clear", 0, 32'(push_error));
		end_test();
	endtask

	task automatic test_drain_pop_error();
		start_test("drain_pop_error");
		// A request while not empty raises no error
		pop_edge();
		pop_req_n = 1'b0;
		pop_edge();
		check_val("pop_error not empty", 0, 32'(pop_error));
		pop_req_n = 1'b1;
		read_burst(model_count());
		check_val("pop_empty", 32'(1'b1), 32'(pop_empty));
		repeat (settle_cycles) push_edge();
		check_val("push_empty", 32'(1'b1), 32'(push_empty));
		check_val("push_ae", 32'(1'b1), 32'(push_ae));
		check_push_steady();
		pop_edge();
		pop_req_n = 1'b0;
		pop_edge();
		check_val("pop_error set", 32'(1'b1), 32'(pop_error));
		pop_req_n = 1'b1;
		pop_edge();
		check_val("pop_error clear", 0, 32'(pop_error));
		end_test();
	endtask

	// Second full cycle takes the pointers past 2*depth
	task automatic test_wrap_refill();
		start_test("wrap_refill");
		write_burst(depth);
		repeat (settle_cycles) pop_edge();
		check_pop_steady();
		read_burst(depth);
		repeat (settle_cycles) push_edge();
		check_push_steady();
		check_val("wr_addr", 0, 32'(wr_addr));
		check_val("rd_addr", 0, 32'(rd_addr));
		end_test();
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------

	initial
	begin
		void'($urandom(32'h8b00b267));
		rst_n = 1'b0;
		write_allow = 1'b0;
		push_req_n = 1'b1;
		ren = 1'b0;
		pop_req_n = 1'b1;
		wr_m = '0;
		rd_m = '0;
		err_count = 0;
		test_err_start = 0;
		tests_passed = 0;
		tests_failed = 0;
		cur_test = "";
		repeat (16) @(posedge clk_push);
		#1;
		rst_n = 1'b1;
		test_reset_values();
		test_write_burst();
		test_cross_to_pop();
		test_fill_push_error();
		test_drain_pop_error();
		test_wrap_refill();
		$display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
			tests_passed, tests_failed, err_count);
		if (tests_failed == 0 && err_count == 0)
		begin
			$display("Test completed successfully");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- fifoctl.f
fifoctl_cfg_pkg.sv
fifoctl_ptr_pkg.sv
ptr_sync.sv
status_flags.sv
push_ctl.sv
pop_ctl.sv
fifoctl_top.sv
tb_fifoctl.sv

//--- Makefile
TOP = tb_fifoctl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/10ps --top-module $(TOP) \
		-f fifoctl.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
